/* mesh_pkg.sv */
// mini mesh shared definitions: coordinate widths, flit layout, opcodes, port indices
`default_nettype none

package mesh_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // column coordinate, two columns in the default build
  parameter int x_cord_w = 1;
  // row coordinate, io row 0 plus the tile rows below it
  parameter int y_cord_w = 2;
  // payload word
  parameter int data_w   = 32;
  // word address inside one tile, 16 words
  parameter int addr_w   = 4;

  typedef logic [x_cord_w-1:0] x_cord_t;
  typedef logic [y_cord_w-1:0] y_cord_t;

  // --------------------------------------------------
  // packet format
  // --------------------------------------------------

  // opcode 2'd3 is unused and treated as a discard everywhere
  typedef enum logic [1:0] {
    op_write = 2'd0,
    op_read  = 2'd1,
    op_reply = 2'd2
  } op_e;

  // one flit is one whole packet, opcode sits in the top bits
  typedef struct packed {
    op_e                op;
    x_cord_t            dst_x;
    y_cord_t            dst_y;
    x_cord_t            src_x;
    y_cord_t            src_y;
    logic [addr_w-1:0]  addr;
    logic [data_w-1:0]  data;
  } flit_t;

  // router port index; the type carries _idx since dir_e is the east value
  typedef enum logic [2:0] {
    dir_p = 3'd0,
    dir_w = 3'd1,
    dir_e = 3'd2,
    dir_n = 3'd3,
    dir_s = 3'd4
  } dir_idx_e;

endpackage

`default_nettype wire

/* mesh_fifo.sv */
// mesh fifo: small circular buffer with a generic payload and valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module mesh_fifo
  #(parameter type payload_t = logic [31:0]
    , parameter int depth_p = 2
  )
  (
    input  logic     clk_i
    , input  logic     rst_n_i
    // write side
    , input  payload_t data_i
    , input  logic     valid_i
    , output logic     ready_o
    // read side
    , output payload_t data_o
    , output logic     valid_o
    , input  logic     ready_i
  );

  // a depth of one still needs a one bit pointer
  localparam int ptr_w = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w = $clog2(depth_p + 1);

  payload_t          mem_q [depth_p];
  logic [ptr_w-1:0]  wr_ptr_q;
  logic [ptr_w-1:0]  rd_ptr_q;
  logic [cnt_w-1:0]  count_q;
  logic              push;
  logic              pop;

  // full drops ready, empty drops valid
  assign ready_o = (count_q != cnt_w'(depth_p));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      // pointers wrap at depth_p, not at a power of two
      if (push)
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  // storage, word shows at data_o the cycle after the write
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

/* mesh_router.sv */
// mesh router: five-port dimension-ordered router with input fifos and round-robin outputs
`timescale 1ns/1ps
`default_nettype none

module mesh_router
  #(parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
    , parameter int fifo_depth_p = 2
  )
  (
    input  logic              clk_i
    , input  logic              rst_n_i
    , input  mesh_pkg::x_cord_t my_x_i
    , input  mesh_pkg::y_cord_t my_y_i
    // inputs, indexed p w e n s
    , input  mesh_pkg::flit_t   flit_i [5]
    , input  logic [4:0]        valid_i
    , output logic [4:0]        ready_o
    // outputs, same indexing
    , output mesh_pkg::flit_t   flit_o [5]
    , output logic [4:0]        valid_o
    , input  logic [4:0]        ready_i
  );

  mesh_pkg::flit_t     head_flit [5];
  logic [4:0]          head_valid;
  logic [4:0]          head_pop;
  logic [4:0]          head_drop;
  mesh_pkg::dir_idx_e  head_dir [5];
  // take[o][i] set when output o moves the head of input i this cycle
  logic [4:0]          take [5];

  // --------------------------------------------------
  // input side: buffer and route computation
  // --------------------------------------------------
  for (genvar i = 0; i < 5; i++)
  begin : g_in
    mesh_fifo
      #(.payload_t (mesh_pkg::flit_t)
        , .depth_p (fifo_depth_p)
      )
    u_fifo
      (.clk_i    (clk_i)
        , .rst_n_i (rst_n_i)
        , .data_i  (flit_i[i])
        , .valid_i (valid_i[i])
        , .ready_o (ready_o[i])
        , .data_o  (head_flit[i])
        , .valid_o (head_valid[i])
        , .ready_i (head_pop[i])
      );

    // destinations outside the grid would leave through a tied-off edge
    // and are simply eaten here
    assign head_drop[i] = (int'(head_flit[i].dst_x) >= num_tiles_x_p)
                       || (int'(head_flit[i].dst_y) > num_tiles_y_p);

    // x first, then y, then eject; row 0 is the north edge
    assign head_dir[i] = (head_flit[i].dst_x < my_x_i) ? mesh_pkg::dir_w
                       : (head_flit[i].dst_x > my_x_i) ? mesh_pkg::dir_e
                       : (head_flit[i].dst_y < my_y_i) ? mesh_pkg::dir_n
                       : (head_flit[i].dst_y > my_y_i) ? mesh_pkg::dir_s
                       : mesh_pkg::dir_p;

    // a head leaves when some output takes it or when it is dropped
    assign head_pop[i] = (head_valid[i] && head_drop[i])
                       | take[0][i] | take[1][i] | take[2][i] | take[3][i] | take[4][i];
  end

  // --------------------------------------------------
  // output side: arbiter and output register
  // --------------------------------------------------
  for (genvar o = 0; o < 5; o++)
  begin : g_out
    logic [4:0]       req;
    logic [2:0]       rr_q;
    logic [2:0]       gnt_idx;
    logic             gnt_any;
    logic             load;
    logic             out_valid_q;
    mesh_pkg::flit_t  out_flit_q;

    always_comb
    begin
      for (int i = 0; i < 5; i++)
        req[i] = head_valid[i] && !head_drop[i] && (int'(head_dir[i]) == o);
    end

    // round robin, search starts one past the last winner
    always_comb
    begin
      int idx;
      gnt_any = 1'b0;
      gnt_idx = rr_q;
      for (int k = 1; k <= 5; k++)
      begin
        idx = (int'(rr_q) + k) % 5;
        if (!gnt_any && req[idx])
        begin
          gnt_any = 1'b1;
          gnt_idx = 3'(idx);
        end
      end
    end

    // register is free, or empties on this edge
    assign load    = gnt_any && (!out_valid_q || ready_i[o]);
    assign take[o] = load ? (5'b00001 << gnt_idx) : 5'b00000;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
      begin
        out_valid_q <= 1'b0;
        // 4 so input 0 is searched first after reset
        rr_q        <= 3'd4;
      end
      else if (load)
      begin
        out_valid_q <= 1'b1;
        rr_q        <= gnt_idx;
      end
      else if (ready_i[o])
        out_valid_q <= 1'b0;
    end

    always_ff @(posedge clk_i)
    begin
      if (load)
        out_flit_q <= head_flit[gnt_idx];
    end

    // flit and valid stay put until ready_i lets them go
    assign flit_o[o]  = out_flit_q;
    assign valid_o[o] = out_valid_q;
  end

endmodule

`default_nettype wire

/* mesh_tile.sv */
// mesh tile: word memory behind the local router port, serves writes and answers reads
`timescale 1ns/1ps
`default_nettype none

module mesh_tile
  #(parameter int fifo_depth_p = 2
  )
  (
    input  logic              clk_i
    , input  logic              rst_n_i
    , input  mesh_pkg::x_cord_t my_x_i
    , input  mesh_pkg::y_cord_t my_y_i
    // requests from the router
    , input  mesh_pkg::flit_t   flit_i
    , input  logic              valid_i
    , output logic              ready_o
    // replies toward the router
    , output mesh_pkg::flit_t   flit_o
    , output logic              valid_o
    , input  logic              ready_i
  );

  // reply record, source fields are added on the way out
  typedef struct packed {
    mesh_pkg::op_e                op;
    mesh_pkg::x_cord_t            dst_x;
    mesh_pkg::y_cord_t            dst_y;
    logic [mesh_pkg::addr_w-1:0]  addr;
    logic [mesh_pkg::data_w-1:0]  data;
  } reply_t;

  logic [mesh_pkg::data_w-1:0] mem_q [1 << mesh_pkg::addr_w];
  reply_t  rply_in;
  reply_t  rply_out;
  logic    rply_push;
  logic    rply_space;
  logic    rply_valid;
  logic    accept;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------

  // stall while a reply sits unaccepted at the output
  assign ready_o   = rply_space && !(rply_valid && !ready_i);
  assign accept    = valid_i && ready_o;
  // reply opcodes and the unused code are accepted and dropped
  assign rply_push = accept && (flit_i.op == mesh_pkg::op_read);

  // memory clears on reset, so reads before any write give 0
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int w = 0; w < (1 << mesh_pkg::addr_w); w++)
        mem_q[w] <= '0;
    end
    else if (accept && (flit_i.op == mesh_pkg::op_write))
      mem_q[flit_i.addr] <= flit_i.data;
  end

  // reply goes back to whoever asked
  always_comb
  begin
    rply_in.op    = mesh_pkg::op_reply;
    rply_in.dst_x = flit_i.src_x;
    rply_in.dst_y = flit_i.src_y;
    rply_in.addr  = flit_i.addr;
    rply_in.data  = mem_q[flit_i.addr];
  end

  // --------------------------------------------------
  // reply side
  // --------------------------------------------------
  mesh_fifo
    #(.payload_t (reply_t)
      , .depth_p (fifo_depth_p)
    )
  u_reply_fifo
    (.clk_i    (clk_i)
      , .rst_n_i (rst_n_i)
      , .data_i  (rply_in)
      , .valid_i (rply_push)
      , .ready_o (rply_space)
      , .data_o  (rply_out)
      , .valid_o (rply_valid)
      , .ready_i (ready_i)
    );

  always_comb
  begin
    flit_o.op    = rply_out.op;
    flit_o.dst_x = rply_out.dst_x;
    flit_o.dst_y = rply_out.dst_y;
    flit_o.src_x = my_x_i;
    flit_o.src_y = my_y_i;
    flit_o.addr  = rply_out.addr;
    flit_o.data  = rply_out.data;
  end

  assign valid_o = rply_valid;

endmodule

`default_nettype wire

/* mesh_array.sv */
// mesh array: io router row plus tile rows, reset fan-out and mesh stitching
`timescale 1ns/1ps
`default_nettype none

module mesh_array
  #(parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
    , parameter int fifo_depth_p = 2
    , parameter int reset_depth_p = 3
  )
  (
    input  logic                      clk_i
    , input  logic                      rst_n_i
    // host links, one per column on the io row
    , input  mesh_pkg::flit_t           host_flit_i [num_tiles_x_p]
    , input  logic [num_tiles_x_p-1:0]  host_valid_i
    , output logic [num_tiles_x_p-1:0]  host_ready_o
    , output mesh_pkg::flit_t           host_flit_o [num_tiles_x_p]
    , output logic [num_tiles_x_p-1:0]  host_valid_o
    , input  logic [num_tiles_x_p-1:0]  host_ready_i
  );

  // io row sits at y = 0, tile rows follow
  localparam int num_rows_lp = num_tiles_y_p + 1;

  // router-side view: in_* enter a router, out_* leave it
  mesh_pkg::flit_t     in_flit   [num_rows_lp][num_tiles_x_p][5];
  logic [4:0]          in_valid  [num_rows_lp][num_tiles_x_p];
  logic [4:0]          in_ready  [num_rows_lp][num_tiles_x_p];
  mesh_pkg::flit_t     out_flit  [num_rows_lp][num_tiles_x_p][5];
  logic [4:0]          out_valid [num_rows_lp][num_tiles_x_p];
  logic [4:0]          out_ready [num_rows_lp][num_tiles_x_p];
  logic [reset_depth_p-1:0] rst_pipe_q [num_rows_lp];

  // --------------------------------------------------
  // reset pipeline, one chain per row
  // --------------------------------------------------
  for (genvar r = 0; r < num_rows_lp; r++)
  begin : g_rst
    // ones shift in after release, last stage drops reset_depth_p cycles later
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        rst_pipe_q[r] <= '0;
      else
        rst_pipe_q[r] <= (rst_pipe_q[r] << 1) | reset_depth_p'(1);
    end
  end

  // --------------------------------------------------
  // routers, tiles and links
  // --------------------------------------------------
  for (genvar r = 0; r < num_rows_lp; r++)
  begin : g_row
    for (genvar c = 0; c < num_tiles_x_p; c++)
    begin : g_col
      mesh_router
        #(.num_tiles_x_p  (num_tiles_x_p)
          , .num_tiles_y_p (num_tiles_y_p)
          , .fifo_depth_p  (fifo_depth_p)
        )
      u_router
        (.clk_i    (clk_i)
          , .rst_n_i (rst_pipe_q[r][reset_depth_p-1])
          , .my_x_i  (mesh_pkg::x_cord_t'(c))
          , .my_y_i  (mesh_pkg::y_cord_t'(r))
          , .flit_i  (in_flit[r][c])
          , .valid_i (in_valid[r][c])
          , .ready_o (in_ready[r][c])
          , .flit_o  (out_flit[r][c])
          , .valid_o (out_valid[r][c])
          , .ready_i (out_ready[r][c])
        );

      // west neighbor, or the west edge
      if (c > 0)
      begin : g_w
        assign in_flit[r][c][mesh_pkg::dir_w]   = out_flit[r][c-1][mesh_pkg::dir_e];
        assign in_valid[r][c][mesh_pkg::dir_w]  = out_valid[r][c-1][mesh_pkg::dir_e];
        assign out_ready[r][c][mesh_pkg::dir_w] = in_ready[r][c-1][mesh_pkg::dir_e];
      end
      else
      begin : g_w_edge
        assign in_flit[r][c][mesh_pkg::dir_w]   = '0;
        assign in_valid[r][c][mesh_pkg::dir_w]  = 1'b0;
        assign out_ready[r][c][mesh_pkg::dir_w] = 1'b1;
      end

      // east
      if (c < num_tiles_x_p - 1)
      begin : g_e
        assign in_flit[r][c][mesh_pkg::dir_e]   = out_flit[r][c+1][mesh_pkg::dir_w];
        assign in_valid[r][c][mesh_pkg::dir_e]  = out_valid[r][c+1][mesh_pkg::dir_w];
        assign out_ready[r][c][mesh_pkg::dir_e] = in_ready[r][c+1][mesh_pkg::dir_w];
      end
      else
      begin : g_e_edge
        assign in_flit[r][c][mesh_pkg::dir_e]   = '0;
        assign in_valid[r][c][mesh_pkg::dir_e]  = 1'b0;
        assign out_ready[r][c][mesh_pkg::dir_e] = 1'b1;
      end

      // north, the io row has nothing above it
      if (r > 0)
      begin : g_n
        assign in_flit[r][c][mesh_pkg::dir_n]   = out_flit[r-1][c][mesh_pkg::dir_s];
        assign in_valid[r][c][mesh_pkg::dir_n]  = out_valid[r-1][c][mesh_pkg::dir_s];
        assign out_ready[r][c][mesh_pkg::dir_n] = in_ready[r-1][c][mesh_pkg::dir_s];
      end
      else
      begin : g_n_edge
        assign in_flit[r][c][mesh_pkg::dir_n]   = '0;
        assign in_valid[r][c][mesh_pkg::dir_n]  = 1'b0;
        assign out_ready[r][c][mesh_pkg::dir_n] = 1'b1;
      end

      // south, last tile row is the far edge
      if (r < num_rows_lp - 1)
      begin : g_s
        assign in_flit[r][c][mesh_pkg::dir_s]   = out_flit[r+1][c][mesh_pkg::dir_n];
        assign in_valid[r][c][mesh_pkg::dir_s]  = out_valid[r+1][c][mesh_pkg::dir_n];
        assign out_ready[r][c][mesh_pkg::dir_s] = in_ready[r+1][c][mesh_pkg::dir_n];
      end
      else
      begin : g_s_edge
        assign in_flit[r][c][mesh_pkg::dir_s]   = '0;
        assign in_valid[r][c][mesh_pkg::dir_s]  = 1'b0;
        assign out_ready[r][c][mesh_pkg::dir_s] = 1'b1;
      end

      // local port: host on the io row, a tile everywhere else
      if (r == 0)
      begin : g_host
        assign in_flit[r][c][mesh_pkg::dir_p]   = host_flit_i[c];
        assign in_valid[r][c][mesh_pkg::dir_p]  = host_valid_i[c];
        assign host_ready_o[c]                  = in_ready[r][c][mesh_pkg::dir_p];
        assign host_flit_o[c]                   = out_flit[r][c][mesh_pkg::dir_p];
        assign host_valid_o[c]                  = out_valid[r][c][mesh_pkg::dir_p];
        assign out_ready[r][c][mesh_pkg::dir_p] = host_ready_i[c];
      end
      else
      begin : g_tile
        mesh_tile
          #(.fifo_depth_p (fifo_depth_p)
          )
        u_tile
          (.clk_i    (clk_i)
            , .rst_n_i (rst_pipe_q[r][reset_depth_p-1])
            , .my_x_i  (mesh_pkg::x_cord_t'(c))
            , .my_y_i  (mesh_pkg::y_cord_t'(r))
            , .flit_i  (out_flit[r][c][mesh_pkg::dir_p])
            , .valid_i (out_valid[r][c][mesh_pkg::dir_p])
            , .ready_o (out_ready[r][c][mesh_pkg::dir_p])
            , .flit_o  (in_flit[r][c][mesh_pkg::dir_p])
            , .valid_o (in_valid[r][c][mesh_pkg::dir_p])
            , .ready_i (in_ready[r][c][mesh_pkg::dir_p])
          );
      end
    end
  end

endmodule

`default_nettype wire

/* mesh_assert.sv */
// mesh host port assertions: quiet reset, held replies stay stable, only replies leave
`timescale 1ns/1ps
`default_nettype none

module mesh_assert
  #(parameter int num_tiles_x_p = 2
  )
  (
    input  logic                      clk_i
    , input  logic                      rst_n_i
    // host output side of the array, one link per column
    , input  mesh_pkg::flit_t           rsp_flit_i [num_tiles_x_p]
    , input  logic [num_tiles_x_p-1:0]  rsp_valid_i
    , input  logic [num_tiles_x_p-1:0]  rsp_ready_i
  );

  for (genvar c = 0; c < num_tiles_x_p; c++)
  begin : g_col
    // nothing leaves a host port while reset is held
    a_quiet_in_reset : assert property (@(posedge clk_i) !rst_n_i |-> !rsp_valid_i[c])
      else $error("host column %0d raised valid_o during reset", c);

    // a stalled reply keeps its valid and its flit
    a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_i[c] && !rsp_ready_i[c] |=> rsp_valid_i[c] && $stable(rsp_flit_i[c]))
      else $error("host column %0d changed a reply that was waiting for ready", c);

    // requests never come back out of the io row
    a_reply_only : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_i[c] |-> rsp_flit_i[c].op == mesh_pkg::op_reply)
      else $error("host column %0d put out a flit with opcode %0d", c, rsp_flit_i[c].op);
  end

endmodule

`default_nettype wire

/* mesh_checker.sv */
// mesh checker: watches the host links, models the tile memories and scores each reply
`timescale 1ns/1ps
`default_nettype none

module mesh_checker
  #(parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
  )
  (
    input  logic                      clk_i
    , input  logic                      rst_n_i
    // host to array
    , input  mesh_pkg::flit_t           req_flit_i [num_tiles_x_p]
    , input  logic [num_tiles_x_p-1:0]  req_valid_i
    , input  logic [num_tiles_x_p-1:0]  req_ready_i
    // array to host
    , input  mesh_pkg::flit_t           rsp_flit_i [num_tiles_x_p]
    , input  logic [num_tiles_x_p-1:0]  rsp_valid_i
    , input  logic [num_tiles_x_p-1:0]  rsp_ready_i
    // test bookkeeping from the testbench
    , input  logic [3:0]                test_idx_i
    , input  logic                      test_end_i
    , output int                        pass_cnt_o
    , output int                        fail_cnt_o
  );

  localparam int num_tiles_lp = num_tiles_x_p * num_tiles_y_p;
  localparam int words_lp     = 1 << mesh_pkg::addr_w;
  localparam int exp_w_lp     = mesh_pkg::addr_w + mesh_pkg::data_w;

  // model of every tile memory
  logic [mesh_pkg::data_w-1:0] model_mem [num_tiles_lp][words_lp];
  // expected {addr, data}, one queue per host column and tile pair
  logic [exp_w_lp-1:0]         exp_q [num_tiles_x_p * num_tiles_lp][$];
  int reads_seen   = 0;
  int replies_seen = 0;
  int err_cnt      = 0;

  initial
  begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
  end

  function automatic string test_name(input int idx);
    case (idx)
      0: return "reset";
      1: return "write_read";
      2: return "reply_routing";
      3: return "ordering";
      4: return "back_pressure";
      5: return "contention";
      default: return "unknown";
    endcase
  endfunction

  // row 1 holds tiles 0 .. x-1, row 2 the next x
  function automatic int tile_num(input int x, input int y);
    return (y - 1) * num_tiles_x_p + x;
  endfunction

  // --------------------------------------------------
  // reply scoring
  // --------------------------------------------------
  task automatic check_reply(input int c, input mesh_pkg::flit_t f);
    int                  t;
    int                  k;
    logic [exp_w_lp-1:0] e;
    replies_seen++;
    if (f.op != mesh_pkg::op_reply)
    begin
      $display("column %0d delivered a flit that is not a reply", c);
      err_cnt++;
    end
    else if (int'(f.src_y) < 1 || int'(f.src_y) > num_tiles_y_p
             || int'(f.src_x) >= num_tiles_x_p)
    begin
      $display("column %0d got a reply whose source is not a tile", c);
      err_cnt++;
    end
    else
    begin
      t = tile_num(int'(f.src_x), int'(f.src_y));
      k = c * num_tiles_lp + t;
      if (exp_q[k].size() == 0)
      begin
        $display("column %0d got a reply from tile %0d with no read waiting", c, t);
        err_cnt++;
      end
      else
      begin
        // oldest read of this pair must answer first
        e = exp_q[k].pop_front();
        if (f.addr != e[exp_w_lp-1 -: mesh_pkg::addr_w])
        begin
          $display("ERR %s: reply addr col %0d tile %0d, expected %0h actual %0h",
                   test_name(int'(test_idx_i)), c, t, e[exp_w_lp-1 -: mesh_pkg::addr_w],
                   f.addr);
          err_cnt++;
        end
        if (f.data != e[mesh_pkg::data_w-1:0])
        begin
          $display("ERR %s: reply data col %0d tile %0d, expected %08h actual %08h",
                   test_name(int'(test_idx_i)), c, t, e[mesh_pkg::data_w-1:0], f.data);
          err_cnt++;
        end
      end
    end
    // reply must be addressed to the io router of this column
    if (int'(f.dst_x) != c || f.dst_y != '0)
    begin
      $display("ERR %s: reply dest on col %0d, expected (%0d,0) actual (%0d,%0d)",
               test_name(int'(test_idx_i)), c, c, f.dst_x, f.dst_y);
      err_cnt++;
    end
  endtask

  // end of test, leftovers mean lost replies
  task automatic close_test();
    int left;
    left = 0;
    for (int k = 0; k < num_tiles_x_p * num_tiles_lp; k++)
    begin
      left += exp_q[k].size();
      exp_q[k].delete();
    end
    if (left != 0)
    begin
      $display("%0d replies never arrived in test %s", left, test_name(int'(test_idx_i)));
      err_cnt++;
    end
    if (replies_seen != reads_seen)
    begin
      $display("ERR %s: reply count, expected %0d actual %0d",
               test_name(int'(test_idx_i)), reads_seen, replies_seen);
      err_cnt++;
    end
    if (err_cnt == 0)
    begin
      $display("test %0d %s: pass, %0d reads, %0d replies", test_idx_i,
               test_name(int'(test_idx_i)), reads_seen, replies_seen);
      pass_cnt_o <= pass_cnt_o + 1;
    end
    else
    begin
      $display("test %0d %s: FAIL, %0d errors", test_idx_i,
               test_name(int'(test_idx_i)), err_cnt);
      fail_cnt_o <= fail_cnt_o + 1;
    end
    reads_seen   = 0;
    replies_seen = 0;
    err_cnt      = 0;
  endtask

  // --------------------------------------------------
  // link monitor
  // --------------------------------------------------
  always @(posedge clk_i)
  begin
    mesh_pkg::flit_t f;
    int              t;
    if (!rst_n_i)
    begin
      // tiles clear on reset
      for (int i = 0; i < num_tiles_lp; i++)
        for (int w = 0; w < words_lp; w++)
          model_mem[i][w] = '0;
      if (rsp_valid_i != '0)
      begin
        $display("host valid_o was high while reset was asserted");
        err_cnt++;
      end
    end
    else
    begin
      for (int c = 0; c < num_tiles_x_p; c++)
      begin
        if (req_valid_i[c] && req_ready_i[c])
        begin
          f = req_flit_i[c];
          t = tile_num(int'(f.dst_x), int'(f.dst_y));
          if (f.op == mesh_pkg::op_write)
            model_mem[t][f.addr] = f.data;
          else if (f.op == mesh_pkg::op_read)
          begin
            exp_q[c * num_tiles_lp + t].push_back({f.addr, model_mem[t][f.addr]});
            reads_seen++;
          end
        end
        if (rsp_valid_i[c] && rsp_ready_i[c])
          check_reply(c, rsp_flit_i[c]);
      end
      if (test_end_i)
        close_test();
    end
  end

endmodule

`default_nettype wire

/* mesh_tb.sv */
// mesh testbench: clock and reset, seeded random host traffic, timeout and final report
`timescale 1ns/1ps
`default_nettype none

module mesh_tb;

  localparam int num_tiles_x_lp = 2;
  localparam int num_tiles_y_lp = 2;
  localparam int fifo_depth_lp  = 2;
  localparam int reset_depth_lp = 3;
  localparam int num_tiles_lp   = num_tiles_x_lp * num_tiles_y_lp;
  localparam int words_lp       = 1 << mesh_pkg::addr_w;
  localparam int addr_w_lp      = mesh_pkg::addr_w;
  localparam int num_tests_lp   = 6;

  // test lengths, host flits per column
  localparam int len_reset_lp = 16;
  localparam int len_wr_rd_lp = 64;
  localparam int len_route_lp = 64;
  localparam int len_order_lp = 64;
  localparam int len_bp_lp    = 96;
  localparam int len_hot_lp   = 32;
  localparam int timeout_lp   = 20 * (len_reset_lp + len_wr_rd_lp + len_route_lp
                                      + len_order_lp + len_bp_lp + len_hot_lp);

  // stimulus modes
  localparam int m_sweep = 0;
  localparam int m_wr_rd = 1;
  localparam int m_mix   = 2;
  localparam int m_rd    = 3;
  localparam int m_hot   = 4;

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  mesh_pkg::flit_t            host_flit_i [num_tiles_x_lp];
  logic [num_tiles_x_lp-1:0]  host_valid_i;
  logic [num_tiles_x_lp-1:0]  host_ready_o;
  mesh_pkg::flit_t            host_flit_o [num_tiles_x_lp];
  logic [num_tiles_x_lp-1:0]  host_valid_o;
  logic [num_tiles_x_lp-1:0]  host_ready_i;
  logic [3:0]                 test_idx;
  logic                       test_end;
  int                         pass_cnt;
  int                         fail_cnt;
  int                         cycle_cnt = 0;

  always #5 clk_i = ~clk_i;

  mesh_array
    #(.num_tiles_x_p  (num_tiles_x_lp)
      , .num_tiles_y_p (num_tiles_y_lp)
      , .fifo_depth_p  (fifo_depth_lp)
      , .reset_depth_p (reset_depth_lp)
    )
  u_mesh_array
    (.clk_i          (clk_i)
      , .rst_n_i      (rst_n_i)
      , .host_flit_i  (host_flit_i)
      , .host_valid_i (host_valid_i)
      , .host_ready_o (host_ready_o)
      , .host_flit_o  (host_flit_o)
      , .host_valid_o (host_valid_o)
      , .host_ready_i (host_ready_i)
    );

  mesh_checker
    #(.num_tiles_x_p  (num_tiles_x_lp)
      , .num_tiles_y_p (num_tiles_y_lp)
    )
  u_checker
    (.clk_i         (clk_i)
      , .rst_n_i     (rst_n_i)
      , .req_flit_i  (host_flit_i)
      , .req_valid_i (host_valid_i)
      , .req_ready_i (host_ready_o)
      , .rsp_flit_i  (host_flit_o)
      , .rsp_valid_i (host_valid_o)
      , .rsp_ready_i (host_ready_i)
      , .test_idx_i  (test_idx)
      , .test_end_i  (test_end)
      , .pass_cnt_o  (pass_cnt)
      , .fail_cnt_o  (fail_cnt)
    );

  bind mesh_array mesh_assert
    #(.num_tiles_x_p (num_tiles_x_p)
    )
  u_mesh_assert
    (.clk_i         (clk_i)
      , .rst_n_i     (rst_n_i)
      , .rsp_flit_i  (host_flit_o)
      , .rsp_valid_i (host_valid_o)
      , .rsp_ready_i (host_ready_i)
    );

  // hard stop well past the expected length of all tests
  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_lp)
    begin
      $display("timeout: %0d cycles passed and traffic was still in flight", timeout_lp);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  function automatic mesh_pkg::op_e pick_op(input int mode, input int idx, input int n);
    if (mode == m_wr_rd)
      return (idx < n / 2) ? mesh_pkg::op_write : mesh_pkg::op_read;
    if (mode == m_mix)
      return ($urandom % 2 == 0) ? mesh_pkg::op_write : mesh_pkg::op_read;
    return mesh_pkg::op_read;
  endfunction

  function automatic int pick_tile(input int mode, input int idx, input int hot);
    if (mode == m_sweep)
      return idx % num_tiles_lp;
    if (mode == m_hot)
      return hot;
    return int'($urandom % num_tiles_lp);
  endfunction

  function automatic mesh_pkg::flit_t make_flit(input mesh_pkg::op_e op, input int c,
                                                input int tile);
    mesh_pkg::flit_t f;
    f.op    = op;
    f.dst_x = mesh_pkg::x_cord_t'(tile % num_tiles_x_lp);
    f.dst_y = mesh_pkg::y_cord_t'(tile / num_tiles_x_lp + 1);
    f.src_x = mesh_pkg::x_cord_t'(c);
    f.src_y = '0;
    // a column owns the addresses equal to its index modulo the column count
    f.addr  = addr_w_lp'(($urandom % (words_lp / num_tiles_x_lp)) * num_tiles_x_lp + c);
    f.data  = (op == mesh_pkg::op_write) ? $urandom : '0;
    return f;
  endfunction

  // one test: all columns issue n flits each, then drain every read
  task automatic run_test(input int t, input int mode, input int n, input bit bp);
    int            issued   [num_tiles_x_lp];
    int            inflight [num_tiles_x_lp];
    bit            holding  [num_tiles_x_lp];
    int            hot;
    bit            busy;
    mesh_pkg::op_e op;
    hot = int'($urandom % num_tiles_lp);
    for (int c = 0; c < num_tiles_x_lp; c++)
    begin
      issued[c]   = 0;
      inflight[c] = 0;
      holding[c]  = 1'b0;
    end
    @(posedge clk_i);
    test_idx <= 4'(t);
    busy = 1'b1;
    while (busy)
    begin
      @(posedge clk_i);
      busy = 1'b0;
      for (int c = 0; c < num_tiles_x_lp; c++)
      begin
        // held flit moved on this edge
        if (holding[c] && host_ready_o[c])
        begin
          holding[c] = 1'b0;
          if (host_flit_i[c].op == mesh_pkg::op_read)
            inflight[c]++;
        end
        if (host_valid_o[c] && host_ready_i[c])
          inflight[c]--;
        if (!holding[c] && issued[c] < n)
        begin
          op = pick_op(mode, issued[c], n);
          // reads wait while fifo_depth reads are out
          if (op != mesh_pkg::op_read || inflight[c] < fifo_depth_lp)
          begin
            host_flit_i[c] <= make_flit(op, c, pick_tile(mode, issued[c], hot));
            holding[c] = 1'b1;
            issued[c]++;
          end
        end
        host_valid_i[c] <= holding[c];
        host_ready_i[c] <= bp ? ($urandom % 4 != 0) : 1'b1;
        if (holding[c] || issued[c] < n || inflight[c] != 0)
          busy = 1'b1;
      end
    end
    // one cycle pulse closes the test in the checker
    test_end <= 1'b1;
    @(posedge clk_i);
    test_end <= 1'b0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    void'($urandom(32'haa62_b50d));
    rst_n_i      = 1'b0;
    host_valid_i = '0;
    host_ready_i = '1;
    test_idx     = '0;
    test_end     = 1'b0;
    for (int c = 0; c < num_tiles_x_lp; c++)
      host_flit_i[c] = '0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // routers and tiles leave reset after the pipeline
    repeat (reset_depth_lp + 1) @(posedge clk_i);
    run_test(0, m_sweep, len_reset_lp, 1'b0);
    run_test(1, m_wr_rd, len_wr_rd_lp, 1'b0);
    run_test(2, m_mix,   len_route_lp, 1'b0);
    run_test(3, m_rd,    len_order_lp, 1'b0);
    run_test(4, m_mix,   len_bp_lp,    1'b1);
    run_test(5, m_hot,   len_hot_lp,   1'b0);
    repeat (2) @(posedge clk_i);
    $display("tests run %0d, passed %0d, failed %0d", num_tests_lp, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == num_tests_lp)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* mini_mesh.f */
mesh_pkg.sv
mesh_fifo.sv
mesh_router.sv
mesh_tile.sv
mesh_array.sv
mesh_assert.sv
mesh_checker.sv
mesh_tb.sv

/* Makefile */
# mini_mesh simulation with verilator

.PHONY: help test clean

help:
	@echo "make test   build the testbench with verilator, run it and check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mesh_tb \
		-Mdir obj_dir -o mesh_sim -f mini_mesh.f
	./obj_dir/mesh_sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
